// ==== run.sh ====
#!/bin/sh
# Compile and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module alu_tb
./obj_dir/Valu_tb | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== sim/alu_tb.sv ====
// ALU testbench
// Directed tests for arithmetic, shifts, compares, bit counts, divider and reset
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_tb;

  localparam int DIV_TIMEOUT = `ALU_DIV_STEPS + 10;  // Cycles allowed for ready_o
  localparam int RST_TIMEOUT = 10;

  logic               clk;
  logic               gen_rst_n;         // Power-on reset
  logic               test_rst_n;        // Pulled low by the reset test
  logic               rst_n;
  alu_pkg::alu_op_e   operator;
  alu_pkg::alu_data_t operand_a;
  alu_pkg::alu_data_t operand_b;
  logic               ex_ready;
  alu_pkg::alu_data_t result;
  logic               comparison_result;
  logic               ready;
  int                 check_count;

  assign rst_n = gen_rst_n & test_rst_n;

  alu_tb_clk alu_tb_clk_i (
    .clk_o   (clk),
    .rst_n_o (gen_rst_n)
  );

  riscv_alu riscv_alu_i (
    .clk                 (clk),
    .rst_n_i             (rst_n),
    .operator_i          (operator),
    .operand_a_i         (operand_a),
    .operand_b_i         (operand_b),
    .ex_ready_i          (ex_ready),
    .result_o            (result),
    .comparison_result_o (comparison_result),
    .ready_o             (ready)
  );

  ////////////////////////////////////////
  // Check, drive and wait helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("CHECK FAILED: %s got %h expected %h", name, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic drive_op(input alu_pkg::alu_op_e op, input alu_pkg::alu_data_t a,
                          input alu_pkg::alu_data_t b);
    @(negedge clk);
    operator  = op;
    operand_a = a;
    operand_b = b;
  endtask

  // Combinational result, sampled half a cycle after the drive
  task automatic expect_comb(input alu_pkg::alu_op_e op, input alu_pkg::alu_data_t a,
                             input alu_pkg::alu_data_t b, input alu_pkg::alu_data_t expected);
    drive_op(op, a, b);
    @(posedge clk);
    check_value({op.name(), " result_o"}, result, expected);
    check_value({op.name(), " ready_o"}, 32'(ready), 32'h1);
  endtask

  task automatic expect_pred(input alu_pkg::alu_op_e op, input alu_pkg::alu_data_t a,
                             input alu_pkg::alu_data_t b, input logic pred);
    drive_op(op, a, b);
    @(posedge clk);
    if (op == alu_pkg::ALU_SLTS || op == alu_pkg::ALU_SLTU) begin
      check_value({op.name(), " result_o"}, result, {{31{1'b0}}, pred});  // 0 or 1
    end else begin
      check_value({op.name(), " result_o"}, result, {32{pred}});  // Full mask
    end
    check_value({op.name(), " comparison_result_o"}, 32'(comparison_result), 32'(pred));
  endtask

  task automatic wait_ready(input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > DIV_TIMEOUT) begin
        $display("Timeout: ready_o never rose during %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "Timeout waiting for ready_o");
      end
    end while (ready !== 1'b1);
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
      if (cycles > RST_TIMEOUT) begin
        $display("Timeout: reset was never released");
        $display("ERRORS FOUND");
        $fatal(1, "Timeout waiting for reset release");
      end
    end
  endtask

  ////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////

  function automatic int lowest_one(input alu_pkg::alu_data_t a);
    for (int i = 0; i < 32; i++) begin
      if (a[i]) return i;
    end
    return 32;  // No ones
  endfunction

  function automatic int highest_one(input alu_pkg::alu_data_t a);
    for (int i = 31; i >= 0; i--) begin
      if (a[i]) return i;
    end
    return 32;
  endfunction

  function automatic int ones_count(input alu_pkg::alu_data_t a);
    int n;
    n = 0;
    for (int i = 0; i < 32; i++) n += a[i];
    return n;
  endfunction

  // Bits below the sign that repeat it
  function automatic int redundant_sign_bits(input alu_pkg::alu_data_t a);
    int n;
    n = 0;
    if (a == '0) return 0;  // Zero is special
    for (int i = 30; i >= 0; i--) begin
      if (a[i] != a[31]) break;
      n++;
    end
    return n;
  endfunction

  // RISC-V divide, including divide by zero and overflow
  function automatic alu_pkg::alu_data_t quotient_or_remainder(input alu_pkg::alu_op_e op,
      input alu_pkg::alu_data_t a, input alu_pkg::alu_data_t b);
    logic overflow;
    overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    case (op)
      alu_pkg::ALU_DIVU: return (b == '0) ? 32'hFFFF_FFFF : a / b;
      alu_pkg::ALU_REMU: return (b == '0) ? a : a % b;
      alu_pkg::ALU_DIV: begin
        if (b == '0) return 32'hFFFF_FFFF;
        if (overflow) return a;
        return $signed(a) / $signed(b);  // Truncates toward zero
      end
      default: begin  // REM
        if (b == '0) return a;
        if (overflow) return '0;
        return $signed(a) % $signed(b);  // Sign of dividend
      end
    endcase
  endfunction

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic arith_logic_ops();
    alu_pkg::alu_data_t a;
    alu_pkg::alu_data_t b;
    for (int n = 0; n < 20; n++) begin
      a = $urandom();
      b = $urandom();
      expect_comb(alu_pkg::ALU_ADD, a, b, a + b);  // Mod 2^32
      expect_comb(alu_pkg::ALU_SUB, a, b, a - b);
      expect_comb(alu_pkg::ALU_AND, a, b, a & b);
      expect_comb(alu_pkg::ALU_OR,  a, b, a | b);
      expect_comb(alu_pkg::ALU_XOR, a, b, a ^ b);
    end
  endtask

  task automatic shift_ops();
    alu_pkg::alu_data_t a;
    alu_pkg::alu_data_t b;
    for (int s = 0; s < 32; s++) begin
      a = $urandom();
      b = ($urandom() & ~32'h1F) | 32'(s);  // Upper bits of B are ignored
      expect_comb(alu_pkg::ALU_SLL, a, b, a << s);
      expect_comb(alu_pkg::ALU_SRL, a, b, a >> s);
      expect_comb(alu_pkg::ALU_SRA, a, b, $signed(a) >>> s);
      expect_comb(alu_pkg::ALU_ROR, a, b, (a >> s) | (a << (32 - s)));
    end
  endtask

  task automatic compare_pair(input alu_pkg::alu_data_t a, input alu_pkg::alu_data_t b);
    logic               lts;
    logic               ltu;
    alu_pkg::alu_data_t mag_a;
    lts   = $signed(a) < $signed(b);
    ltu   = a < b;
    mag_a = a[31] ? -a : a;  // Minimum maps to itself
    expect_pred(alu_pkg::ALU_EQ,   a, b, a == b);
    expect_pred(alu_pkg::ALU_NE,   a, b, a != b);
    expect_pred(alu_pkg::ALU_LTS,  a, b, lts);
    expect_pred(alu_pkg::ALU_LTU,  a, b, ltu);
    expect_pred(alu_pkg::ALU_GES,  a, b, !lts);
    expect_pred(alu_pkg::ALU_GEU,  a, b, !ltu);
    expect_pred(alu_pkg::ALU_SLTS, a, b, lts);
    expect_pred(alu_pkg::ALU_SLTU, a, b, ltu);
    expect_comb(alu_pkg::ALU_MIN,  a, b, lts ? a : b);
    expect_comb(alu_pkg::ALU_MAX,  a, b, lts ? b : a);
    expect_comb(alu_pkg::ALU_MINU, a, b, ltu ? a : b);
    expect_comb(alu_pkg::ALU_MAXU, a, b, ltu ? b : a);
    expect_comb(alu_pkg::ALU_ABS,  a, b, mag_a);
  endtask

  task automatic compare_ops();
    alu_pkg::alu_data_t a;
    for (int n = 0; n < 12; n++) begin
      a = $urandom();
      compare_pair(a, $urandom());
      compare_pair(a, a);                      // Equal
    end
    compare_pair(32'h8000_0000, 32'h7FFF_FFFF);  // Sign boundary
    compare_pair(32'h7FFF_FFFF, 32'h8000_0000);
    compare_pair(32'hFFFF_FFFF, 32'h0000_0000);
    compare_pair(32'h0000_0000, 32'hFFFF_FFFF);
    compare_pair(32'h8000_0000, 32'h8000_0000);
    compare_pair(32'h1234_5678, 32'h1234_5679);  // Low byte decides
  endtask

  task automatic count_word(input alu_pkg::alu_data_t a);
    expect_comb(alu_pkg::ALU_FF1, a, '0, 32'(lowest_one(a)));
    expect_comb(alu_pkg::ALU_FL1, a, '0, 32'(highest_one(a)));
    expect_comb(alu_pkg::ALU_CNT, a, '0, 32'(ones_count(a)));
    expect_comb(alu_pkg::ALU_CLB, a, '0, 32'(redundant_sign_bits(a)));
  endtask

  task automatic bit_count_ops();
    count_word(32'h0000_0000);
    count_word(32'hFFFF_FFFF);
    for (int i = 0; i < 32; i++) count_word(32'h1 << i);  // Single bits
    for (int n = 0; n < 12; n++) count_word($urandom());
  endtask

  // Full divide handshake with back-pressure
  task automatic divide_case(input alu_pkg::alu_op_e op, input alu_pkg::alu_data_t a,
                             input alu_pkg::alu_data_t b);
    alu_pkg::alu_data_t expected;
    expected = quotient_or_remainder(op, a, b);
    drive_op(op, a, b);
    ex_ready = 1'b0;
    wait_ready(op.name());
    check_value({op.name(), " result_o"}, result, expected);
    repeat (3) begin                         // Pipeline stalled
      @(negedge clk);
      check_value({op.name(), " held ready_o"}, 32'(ready), 32'h1);
      check_value({op.name(), " held result_o"}, result, expected);
    end
    @(negedge clk);
    ex_ready = 1'b1;
    operator = alu_pkg::ALU_ADD;             // Leave before the edge
    @(posedge clk);
  endtask

  task automatic divide_ops();
    alu_pkg::alu_data_t b;
    alu_pkg::alu_op_e   ops [4];
    ops = '{alu_pkg::ALU_DIV, alu_pkg::ALU_DIVU, alu_pkg::ALU_REM, alu_pkg::ALU_REMU};
    foreach (ops[k]) begin
      for (int n = 0; n < 5; n++) begin
        b = $urandom() >> ($urandom() % 28);  // Spread divisor sizes
        if ($urandom() % 2) b = -b;
        divide_case(ops[k], $urandom(), b);
      end
      divide_case(ops[k], $urandom(), '0);              // Divide by zero
      divide_case(ops[k], 32'hF000_0001, '0);
      divide_case(ops[k], 32'h8000_0000, 32'hFFFF_FFFF);  // Overflow pair
      divide_case(ops[k], 32'hFFFF_FFF9, 32'h0000_0002);  // -7 by 2
    end
  endtask

  task automatic reset_during_divide();
    alu_pkg::alu_data_t expected;
    expected = quotient_or_remainder(alu_pkg::ALU_DIVU, 32'h1234_5678, 32'h0000_0013);
    drive_op(alu_pkg::ALU_DIVU, 32'h1234_5678, 32'h0000_0013);
    ex_ready = 1'b0;
    wait_ready("reset test divide");          // Divider holds its result
    check_value("result_o before reset", result, expected);
    test_rst_n = 1'b0;
    repeat (2) @(negedge clk);
    test_rst_n = 1'b1;
    check_value("ready_o after reset", 32'(ready), 32'h0);
    check_value("result_o after reset", result, 32'h0);  // Result register cleared
    operator = alu_pkg::ALU_ADD;
    @(posedge clk);
    check_value("ready_o non-divide", 32'(ready), 32'h1);
    divide_case(alu_pkg::ALU_DIVU, 32'h1234_5678, 32'h0000_0013);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    operator    = alu_pkg::ALU_ADD;
    operand_a   = '0;
    operand_b   = '0;
    ex_ready    = 1'b1;
    test_rst_n  = 1'b1;
    check_count = 0;
    void'($urandom(92174));
    wait_reset_release();
    arith_logic_ops();
    shift_ops();
    compare_ops();
    bit_count_ops();
    divide_ops();
    reset_during_divide();
    if (check_count == 0) begin
      $display("No checks were run");
      $display("ERRORS FOUND");
      $fatal(1, "Empty run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== sim/alu_tb_clk.sv ====
// Testbench clock and power-on reset
// 4 ns clock, reset low for the first 2 rising edges
`timescale 1ns/10ps

module alu_tb_clk (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);  // Release away from the active edge
    rst_n_o = 1'b1;
  end

endmodule

// ==== source/alu_adder.sv ====
// Negating adder for add, subtract and absolute value
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_adder (
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::alu_data_t operand_a_i,
  input  alu_pkg::alu_data_t operand_b_i,
  output alu_pkg::alu_data_t adder_result_o
);

  logic                  negate_a;   // ABS, zero minus A
  logic                  negate_b;   // SUB
  alu_pkg::alu_data_t    adder_op_a;
  alu_pkg::alu_data_t    adder_op_b;
  logic [`ALU_DATA_W:0]  adder_in_a;
  logic [`ALU_DATA_W:0]  adder_in_b;
  logic [`ALU_DATA_W:0]  adder_sum;

  assign negate_a = (operator_i == alu_pkg::ALU_ABS);
  assign negate_b = (operator_i == alu_pkg::ALU_SUB);

  assign adder_op_a = negate_a ? ~operand_a_i : operand_a_i;

  // B drops out for ABS
  always_comb begin
    adder_op_b = operand_b_i;
    if (negate_b) begin
      adder_op_b = ~operand_b_i;
    end else if (negate_a) begin
      adder_op_b = '0;
    end
  end

  // Carry-in rides in the extra low bit
  assign adder_in_a = {adder_op_a, 1'b1};
  assign adder_in_b = {adder_op_b, negate_a | negate_b};
  assign adder_sum  = adder_in_a + adder_in_b;

  assign adder_result_o = adder_sum[`ALU_DATA_W:1];  // Drop carry slot

endmodule

// ==== source/alu_bitcount.sv ====
// Find-first-one tree, population count
// FF1, FL1, CNT and CLB result
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_bitcount (
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::alu_data_t operand_a_i,
  output alu_pkg::alu_cnt_t  count_o
);

  localparam int LEVELS = $clog2(`ALU_DATA_W);

  alu_pkg::alu_data_t  operand_a_rev;
  alu_pkg::alu_data_t  operand_a_neg_rev;
  alu_pkg::alu_data_t  ff_input;
  alu_pkg::alu_shamt_t ff1_index;          // Lowest set bit of ff_input
  logic                ff_no_one;
  alu_pkg::alu_cnt_t   ff1_result;
  alu_pkg::alu_cnt_t   cnt_result;

  for (genvar k = 0; k < `ALU_DATA_W; k++) begin : g_rev
    assign operand_a_rev[k]     = operand_a_i[`ALU_DATA_W-1-k];
    assign operand_a_neg_rev[k] = ~operand_a_i[`ALU_DATA_W-1-k];
  end

  always_comb begin
    case (operator_i)
      alu_pkg::ALU_FL1: ff_input = operand_a_rev;
      alu_pkg::ALU_CLB: ff_input = operand_a_i[`ALU_DATA_W-1] ? operand_a_neg_rev : operand_a_rev;
      default:          ff_input = operand_a_i;  // FF1
    endcase
  end

  ////////////////////////////////////////
  // First-one tree, low index wins
  ////////////////////////////////////////

  for (genvar l = 0; l <= LEVELS; l++) begin : g_ff
    logic [(`ALU_DATA_W>>l)-1:0] sel;
    alu_pkg::alu_shamt_t         idx [`ALU_DATA_W>>l];
    for (genvar n = 0; n < (`ALU_DATA_W>>l); n++) begin : g_node
      if (l == 0) begin : g_leaf
        assign sel[n] = ff_input[n];
        assign idx[n] = alu_pkg::alu_shamt_t'(n);
      end else begin : g_merge
        assign sel[n] = g_ff[l-1].sel[2*n] | g_ff[l-1].sel[2*n+1];
        assign idx[n] = g_ff[l-1].sel[2*n] ? g_ff[l-1].idx[2*n] : g_ff[l-1].idx[2*n+1];
      end
    end
  end

  assign ff1_index  = g_ff[LEVELS].idx[0];
  assign ff_no_one  = ~g_ff[LEVELS].sel[0];
  assign ff1_result = {1'b0, ff1_index};

  ////////////////////////////////////////
  // Popcount adder tree
  ////////////////////////////////////////

  for (genvar l = 0; l <= LEVELS; l++) begin : g_pop
    alu_pkg::alu_cnt_t cnt [`ALU_DATA_W>>l];
    for (genvar n = 0; n < (`ALU_DATA_W>>l); n++) begin : g_node
      if (l == 0) begin : g_leaf
        assign cnt[n] = alu_pkg::alu_cnt_t'(operand_a_i[n]);
      end else begin : g_sum
        assign cnt[n] = g_pop[l-1].cnt[2*n] + g_pop[l-1].cnt[2*n+1];
      end
    end
  end

  assign cnt_result = g_pop[LEVELS].cnt[0];

  always_comb begin
    case (operator_i)
      alu_pkg::ALU_FL1: count_o = ff_no_one ? alu_pkg::alu_cnt_t'(`ALU_DATA_W)
                                            : alu_pkg::alu_cnt_t'(`ALU_DATA_W - 1) - ff1_result;
      alu_pkg::ALU_CNT: count_o = cnt_result;
      alu_pkg::ALU_CLB: begin
        if (ff_no_one) begin  // All zeros or all ones
          count_o = operand_a_i[`ALU_DATA_W-1] ? alu_pkg::alu_cnt_t'(`ALU_DATA_W - 1) : '0;
        end else begin
          count_o = ff1_result - 1'b1;  // Sign bit itself is not redundant
        end
      end
      default: count_o = ff_no_one ? alu_pkg::alu_cnt_t'(`ALU_DATA_W) : ff1_result;  // FF1
    endcase
  end

endmodule

// ==== source/alu_compare.sv ====
// Byte-sliced comparator, comparison flag and lane mask
// Min, max and absolute value select
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_compare (
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::alu_data_t operand_a_i,
  input  alu_pkg::alu_data_t operand_b_i,
  input  alu_pkg::alu_data_t adder_result_i,  // Negated A for ABS
  output logic [3:0]         cmp_mask_o,
  output logic               comparison_result_o,
  output alu_pkg::alu_data_t minmax_result_o
);

  logic               cmp_signed;      // Sign applies on top byte only
  logic               do_min;
  alu_pkg::alu_data_t cmp_b;           // B, or -A for ABS
  logic [3:0]         sign_sel;
  logic [3:0]         is_equal_vec;
  logic [3:0]         is_greater_vec;
  logic               is_equal;
  logic               is_greater;
  logic               cmp_result;
  logic [3:0]         sel_minmax;

  assign cmp_signed = (operator_i == alu_pkg::ALU_LTS)  || (operator_i == alu_pkg::ALU_GES) ||
                      (operator_i == alu_pkg::ALU_SLTS) || (operator_i == alu_pkg::ALU_MIN) ||
                      (operator_i == alu_pkg::ALU_MAX)  || (operator_i == alu_pkg::ALU_ABS);
  assign do_min     = (operator_i == alu_pkg::ALU_MIN)  || (operator_i == alu_pkg::ALU_MINU);
  assign cmp_b      = (operator_i == alu_pkg::ALU_ABS) ? adder_result_i : operand_b_i;
  assign sign_sel   = {cmp_signed, 3'b000};

  ////////////////////////////////////////
  // Per-byte equal and greater
  ////////////////////////////////////////

  for (genvar i = 0; i < 4; i++) begin : g_byte
    assign is_equal_vec[i]   = (operand_a_i[8*i +: 8] == cmp_b[8*i +: 8]);
    assign is_greater_vec[i] = $signed({sign_sel[i] & operand_a_i[8*i+7], operand_a_i[8*i +: 8]})
                               > $signed({sign_sel[i] & cmp_b[8*i+7], cmp_b[8*i +: 8]});
    // Pick A or the other candidate per byte
    assign minmax_result_o[8*i +: 8] = sel_minmax[i] ? operand_a_i[8*i +: 8] : cmp_b[8*i +: 8];
  end

  // Chain from the top byte down
  assign is_equal   = &is_equal_vec;
  assign is_greater = is_greater_vec[3] | (is_equal_vec[3] & (is_greater_vec[2] |
                      (is_equal_vec[2] & (is_greater_vec[1] |
                      (is_equal_vec[1] & is_greater_vec[0])))));

  always_comb begin
    case (operator_i)
      alu_pkg::ALU_NE:   cmp_result = ~is_equal;
      alu_pkg::ALU_GES,
      alu_pkg::ALU_GEU:  cmp_result = is_greater | is_equal;
      alu_pkg::ALU_LTS,
      alu_pkg::ALU_LTU,
      alu_pkg::ALU_SLTS,
      alu_pkg::ALU_SLTU: cmp_result = ~(is_greater | is_equal);
      default:           cmp_result = is_equal;  // EQ
    endcase
  end

  assign cmp_mask_o          = {4{cmp_result}};  // Full word, all lanes agree
  assign comparison_result_o = cmp_result;

  // Max keeps the greater A, min flips it
  assign sel_minmax = {4{is_greater ^ do_min}};

endmodule

// ==== source/alu_div.sv ====
// Sequential restoring divider, one quotient bit per cycle
// Signed and unsigned quotient and remainder with RISC-V corner cases
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_div (
  input  logic               clk,
  input  logic               rst_n_i,
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::alu_data_t operand_a_i,   // Dividend
  input  alu_pkg::alu_data_t operand_b_i,   // Divisor
  input  logic               ex_ready_i,
  output alu_pkg::alu_data_t div_result_o,
  output logic               div_done_o
);

  localparam int STEP_W = $clog2(`ALU_DIV_STEPS + 1);

  alu_pkg::div_state_e  state_q;
  logic [STEP_W-1:0]    step_q;
  logic                 div_op;
  logic                 signed_op;
  logic                 sign_a;
  logic                 sign_b;
  logic                 last_step;
  alu_pkg::alu_data_t   quo_q;        // Dividend out, quotient in
  alu_pkg::alu_data_t   rem_q;
  alu_pkg::alu_data_t   divisor_q;    // Magnitude
  logic                 is_rem_q;
  logic                 neg_quo_q;
  logic                 neg_rem_q;
  logic                 zero_q;       // Divide by zero
  logic [`ALU_DATA_W:0] rem_shift;
  logic [`ALU_DATA_W:0] rem_diff;     // MSB set when divisor does not fit
  alu_pkg::alu_data_t   quo_fix;
  alu_pkg::alu_data_t   rem_fix;
  alu_pkg::alu_data_t   div_result_q;

  assign div_op    = (operator_i == alu_pkg::ALU_DIV) || (operator_i == alu_pkg::ALU_DIVU) ||
                     (operator_i == alu_pkg::ALU_REM) || (operator_i == alu_pkg::ALU_REMU);
  assign signed_op = (operator_i == alu_pkg::ALU_DIV) || (operator_i == alu_pkg::ALU_REM);
  assign sign_a    = signed_op & operand_a_i[`ALU_DATA_W-1];
  assign sign_b    = signed_op & operand_b_i[`ALU_DATA_W-1];
  assign last_step = (step_q == STEP_W'(`ALU_DIV_STEPS));

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q      <= alu_pkg::DIV_IDLE;
      step_q       <= '0;
      div_result_q <= '0;
    end else begin
      case (state_q)
        alu_pkg::DIV_IDLE: begin
          step_q <= '0;
          if (div_op) begin
            state_q <= alu_pkg::DIV_RUN;  // Operands latched below
          end
        end
        alu_pkg::DIV_RUN: begin
          if (last_step) begin
            div_result_q <= is_rem_q ? rem_fix : quo_fix;
            state_q      <= alu_pkg::DIV_DONE;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        alu_pkg::DIV_DONE: begin
          if (ex_ready_i) begin  // Hold result under back-pressure
            state_q <= alu_pkg::DIV_IDLE;
          end
        end
        default: state_q <= alu_pkg::DIV_IDLE;
      endcase
    end
  end

  // Restoring step
  assign rem_shift = {rem_q, quo_q[`ALU_DATA_W-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor_q};

  always_ff @(posedge clk) begin
    if (state_q == alu_pkg::DIV_IDLE) begin
      quo_q     <= sign_a ? -operand_a_i : operand_a_i;
      divisor_q <= sign_b ? -operand_b_i : operand_b_i;
      rem_q     <= '0;
      is_rem_q  <= (operator_i == alu_pkg::ALU_REM) || (operator_i == alu_pkg::ALU_REMU);
      neg_quo_q <= sign_a ^ sign_b;
      neg_rem_q <= sign_a;                  // Remainder follows dividend
      zero_q    <= (operand_b_i == '0);
    end else if (state_q == alu_pkg::DIV_RUN && !last_step) begin
      rem_q <= rem_diff[`ALU_DATA_W] ? rem_shift[`ALU_DATA_W-1:0] : rem_diff[`ALU_DATA_W-1:0];
      quo_q <= {quo_q[`ALU_DATA_W-2:0], ~rem_diff[`ALU_DATA_W]};
    end
  end

  // Zero divisor gives all ones, remainder comes out as |A| and resigns to A
  // MIN / -1 wraps back to MIN with remainder 0 through the magnitudes
  assign quo_fix = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;

  assign div_result_o = div_result_q;
  assign div_done_o   = (state_q == alu_pkg::DIV_DONE);

endmodule

// ==== source/alu_params.svh ====
// Width and step-count constants shared by the ALU sources
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

`define ALU_DATA_W    32  // Data word
`define ALU_SHAMT_W   5   // Shift amount, bit index
`define ALU_CNT_W     6   // Bit count result, 0 to 32
`define ALU_OP_W      5   // Operator code
`define ALU_DIV_STEPS 32  // Restoring divider iterations

`endif

// ==== source/alu_pkg.sv ====
// ALU types
// Operator codes, divider states and width typedefs
`include "alu_params.svh"

package alu_pkg;

  typedef logic [`ALU_DATA_W-1:0]  alu_data_t;   // One data word
  typedef logic [`ALU_SHAMT_W-1:0] alu_shamt_t;  // Shift amount or bit index
  typedef logic [`ALU_CNT_W-1:0]   alu_cnt_t;    // Count 0..32

  // Operator codes as driven by the decoder
  typedef enum logic [`ALU_OP_W-1:0] {
    ALU_ADD, ALU_SUB,
    ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR,
    ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU,
    ALU_SLTS, ALU_SLTU,
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU, ALU_ABS,
    ALU_FF1, ALU_FL1, ALU_CNT, ALU_CLB,
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
  } alu_op_e;

  // Sequential divider FSM
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

endpackage

// ==== source/alu_shifter.sv ====
// Right shifter serving all shifts and the rotate
// Left shifts wrap the shifter in bit reversal
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_shifter (
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::alu_data_t operand_a_i,
  input  alu_pkg::alu_shamt_t shamt_i,       // Low bits of operand B
  output alu_pkg::alu_data_t shift_result_o
);

  logic                      shift_left;
  logic                      shift_arith;
  alu_pkg::alu_data_t        operand_a_rev;
  alu_pkg::alu_data_t        shift_op_a;
  logic [2*`ALU_DATA_W-1:0]  shift_wide;      // Upper half holds fill bits
  logic [2*`ALU_DATA_W-1:0]  shift_wide_res;
  alu_pkg::alu_data_t        shift_right_result;
  alu_pkg::alu_data_t        shift_left_result;

  assign shift_left  = (operator_i == alu_pkg::ALU_SLL);
  assign shift_arith = (operator_i == alu_pkg::ALU_SRA);

  // Input and output reversal
  for (genvar k = 0; k < `ALU_DATA_W; k++) begin : g_rev
    assign operand_a_rev[k]     = operand_a_i[`ALU_DATA_W-1-k];
    assign shift_left_result[k] = shift_right_result[`ALU_DATA_W-1-k];
  end

  assign shift_op_a = shift_left ? operand_a_rev : operand_a_i;

  ////////////////////////////////////////
  // Fill: copy of word or sign
  ////////////////////////////////////////

  always_comb begin
    if (operator_i == alu_pkg::ALU_ROR) begin
      shift_wide = {shift_op_a, shift_op_a};  // Low half wraps in
    end else begin
      shift_wide = {{`ALU_DATA_W{shift_arith & shift_op_a[`ALU_DATA_W-1]}}, shift_op_a};
    end
  end

  assign shift_wide_res     = shift_wide >> shamt_i;
  assign shift_right_result = shift_wide_res[`ALU_DATA_W-1:0];

  assign shift_result_o = shift_left ? shift_left_result : shift_right_result;

endmodule

// ==== source/riscv_alu.sv ====
// Scalar ALU top level
// Datapath sections, sequential divider and result multiplexer
`timescale 1ns/10ps
`include "alu_params.svh"

module riscv_alu (
  input  logic               clk,
  input  logic               rst_n_i,
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::alu_data_t operand_a_i,
  input  alu_pkg::alu_data_t operand_b_i,
  input  logic               ex_ready_i,
  output alu_pkg::alu_data_t result_o,
  output logic               comparison_result_o,
  output logic               ready_o
);

  alu_pkg::alu_data_t adder_result;
  alu_pkg::alu_data_t shift_result;
  logic [3:0]         cmp_mask;        // One bit per byte lane
  alu_pkg::alu_data_t cmp_mask_wide;
  alu_pkg::alu_data_t minmax_result;
  alu_pkg::alu_cnt_t  count_result;
  alu_pkg::alu_data_t div_result;
  logic               div_done;
  logic               div_op;

  ////////////////////////////////////////
  // Datapath sections
  ////////////////////////////////////////

  alu_adder alu_adder_i (
    .operator_i     (operator_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .adder_result_o (adder_result)
  );

  alu_shifter alu_shifter_i (
    .operator_i     (operator_i),
    .operand_a_i    (operand_a_i),
    .shamt_i        (operand_b_i[`ALU_SHAMT_W-1:0]),
    .shift_result_o (shift_result)
  );

  alu_compare alu_compare_i (
    .operator_i          (operator_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .adder_result_i      (adder_result),   // -A candidate for ABS
    .cmp_mask_o          (cmp_mask),
    .comparison_result_o (comparison_result_o),
    .minmax_result_o     (minmax_result)
  );

  alu_bitcount alu_bitcount_i (
    .operator_i  (operator_i),
    .operand_a_i (operand_a_i),
    .count_o     (count_result)
  );

  alu_div alu_div_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .operator_i   (operator_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .ex_ready_i   (ex_ready_i),
    .div_result_o (div_result),
    .div_done_o   (div_done)
  );

  ////////////////////////////////////////
  // Result multiplexer
  ////////////////////////////////////////

  assign cmp_mask_wide = {{8{cmp_mask[3]}}, {8{cmp_mask[2]}}, {8{cmp_mask[1]}}, {8{cmp_mask[0]}}};

  always_comb begin
    case (operator_i)
      alu_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      alu_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      alu_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      alu_pkg::ALU_ADD,
      alu_pkg::ALU_SUB:  result_o = adder_result;
      alu_pkg::ALU_SLL, alu_pkg::ALU_SRL,
      alu_pkg::ALU_SRA, alu_pkg::ALU_ROR: result_o = shift_result;
      alu_pkg::ALU_EQ,  alu_pkg::ALU_NE,
      alu_pkg::ALU_LTS, alu_pkg::ALU_LTU,
      alu_pkg::ALU_GES, alu_pkg::ALU_GEU: result_o = cmp_mask_wide;
      alu_pkg::ALU_SLTS,
      alu_pkg::ALU_SLTU: result_o = {{(`ALU_DATA_W-1){1'b0}}, comparison_result_o};
      alu_pkg::ALU_MIN, alu_pkg::ALU_MINU,
      alu_pkg::ALU_MAX, alu_pkg::ALU_MAXU,
      alu_pkg::ALU_ABS:  result_o = minmax_result;
      alu_pkg::ALU_FF1, alu_pkg::ALU_FL1,
      alu_pkg::ALU_CNT, alu_pkg::ALU_CLB:
        result_o = {{(`ALU_DATA_W-`ALU_CNT_W){1'b0}}, count_result};
      alu_pkg::ALU_DIV, alu_pkg::ALU_DIVU,
      alu_pkg::ALU_REM, alu_pkg::ALU_REMU: result_o = div_result;
      default:           result_o = '0;
    endcase
  end

  // Only divides stall the pipeline
  assign div_op  = (operator_i == alu_pkg::ALU_DIV) || (operator_i == alu_pkg::ALU_DIVU) ||
                   (operator_i == alu_pkg::ALU_REM) || (operator_i == alu_pkg::ALU_REMU);
  assign ready_o = div_op ? div_done : 1'b1;

endmodule

// ==== verilog.f ====
+incdir+source
source/alu_pkg.sv
source/alu_adder.sv
source/alu_shifter.sv
source/alu_compare.sv
source/alu_bitcount.sv
source/alu_div.sv
source/riscv_alu.sv
sim/alu_tb_clk.sv
sim/alu_tb.sv
